// File: logic/executePkg.sv
// Execute core shared types
`default_nettype none

package executePkg;

    localparam int dataWidth   = 16; // Operand width
    localparam int regCount    = 8;  // Architectural registers
    localparam int regIdxWidth = 3;  // Register index width
    localparam int instrWidth  = 16; // Instruction word width

    // Opcode in instr[15:11], all other codes are illegal
    typedef enum logic [4:0] {
        OP_ADD   = 5'b00000,
        OP_SUB   = 5'b00001,
        OP_XOR   = 5'b00010,
        OP_ANDN  = 5'b00011,
        OP_ROL   = 5'b00100,
        OP_SLL   = 5'b00101,
        OP_ROR   = 5'b00110,
        OP_SRL   = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_SLBI  = 5'b10010,
        OP_ROLI  = 5'b10100,
        OP_SLLI  = 5'b10101,
        OP_RORI  = 5'b10110,
        OP_SRLI  = 5'b10111,
        OP_LBI   = 5'b11000,
        OP_BTR   = 5'b11001,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    // Low two bits pick the logic op or the shifter mode
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_XOR  = 4'b0010,
        ALU_AND  = 4'b0011,
        ALU_ROL  = 4'b0100,
        ALU_SLL  = 4'b0101,
        ALU_ROR  = 4'b0110,
        ALU_SRL  = 4'b0111,
        ALU_SEQ  = 4'b1000,
        ALU_SLT  = 4'b1001,
        ALU_SLE  = 4'b1010,
        ALU_SCO  = 4'b1011,
        ALU_BTR  = 4'b1100,
        ALU_LBI  = 4'b1101,
        ALU_SLBI = 4'b1110
    } aluOp_e;

    typedef struct packed {
        aluOp_e op;       // Operation select
        logic   invA;     // Invert operand A
        logic   invB;     // Invert operand B
        logic   carryIn;  // Adder carry in
        logic   signedOp; // Signed overflow rule
    } aluCtrl_t;

    typedef struct packed {
        logic zero;     // Sum is zero
        logic sign;     // Top bit of sum
        logic overflow; // Signed overflow or carry out
        logic carry;    // Adder carry out
    } aluFlags_t;

endpackage

`default_nettype wire

// File: logic/shifter.sv
// Rotate and shift unit
`timescale 1ns/1ps
`default_nettype none

module shifter (
    input  logic [executePkg::dataWidth-1:0] value,
    input  logic [3:0]                       amount,
    input  logic [1:0]                       mode,   // Low bits of the ALU op
    output logic [executePkg::dataWidth-1:0] shifted
);
    import executePkg::*;

    logic [dataWidth-1:0] stage [0:4]; // stage[0] is the input word

    assign stage[0] = value;

    // One stage per amount bit, moving by 1, 2, 4 and 8
    for (genvar i = 0; i < 4; i++) begin : gStage
        localparam int step = 1 << i;

        logic [dataWidth-1:0] moved;

        always_comb begin
            case (mode)
                2'b00: moved = {stage[i][dataWidth-1-step:0],
                                stage[i][dataWidth-1 -: step]};     // Rotate left
                2'b01: moved = {stage[i][dataWidth-1-step:0],
                                {step{1'b0}}};                      // Shift left
                2'b10: moved = {stage[i][step-1:0],
                                stage[i][dataWidth-1:step]};        // Rotate right
                default: moved = {{step{1'b0}},
                                  stage[i][dataWidth-1:step]};      // Shift right
            endcase
        end

        assign stage[i+1] = amount[i] ? moved : stage[i];
    end

    assign shifted = stage[4];

endmodule

`default_nettype wire

// File: logic/alu.sv
// Sixteen-bit ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [executePkg::dataWidth-1:0] operandA,
    input  logic [executePkg::dataWidth-1:0] operandB,
    input  executePkg::aluCtrl_t             ctrl,
    output logic [executePkg::dataWidth-1:0] result,
    output executePkg::aluFlags_t            flags
);
    import executePkg::*;

    logic [dataWidth-1:0] a;         // Operand A after inversion
    logic [dataWidth-1:0] b;         // Operand B after inversion
    logic [dataWidth-1:0] sum;
    logic                 carryOut;
    logic [dataWidth-1:0] shiftOut;
    logic [dataWidth-1:0] reversed;  // A in reverse bit order
    logic                 isZero;
    logic                 signedOvf;
    logic                 lessThan;  // Signed A < B from A minus B

    assign a = ctrl.invA ? ~operandA : operandA;
    assign b = ctrl.invB ? ~operandB : operandB;

    assign {carryOut, sum} = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, ctrl.carryIn};

    shifter shifter0 (
        .value  (a),
        .amount (b[3:0]),
        .mode   (ctrl.op[1:0]),
        .shifted(shiftOut)
    );

    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            reversed[i] = a[dataWidth-1-i];
        end
    end

    assign isZero    = (sum == '0);
    assign signedOvf = (a[dataWidth-1] ~^ b[dataWidth-1])
                     & (sum[dataWidth-1] ^ a[dataWidth-1]);

    // Sign of the difference corrected by overflow
    assign lessThan = sum[dataWidth-1] ^ signedOvf;

    assign flags = '{
        zero:     isZero,
        sign:     sum[dataWidth-1],
        overflow: ctrl.signedOp ? signedOvf : carryOut,
        carry:    carryOut
    };

    always_comb begin
        case (ctrl.op)
            ALU_ADD:  result = sum;
            ALU_XOR:  result = a ^ b;
            ALU_AND:  result = a & b;
            ALU_ROL,
            ALU_SLL,
            ALU_ROR,
            ALU_SRL:  result = shiftOut;
            ALU_SEQ:  result = {{(dataWidth-1){1'b0}}, isZero};
            ALU_SLT:  result = {{(dataWidth-1){1'b0}}, lessThan};
            ALU_SLE:  result = {{(dataWidth-1){1'b0}}, lessThan | isZero};
            ALU_SCO:  result = {{(dataWidth-1){1'b0}}, carryOut};
            ALU_BTR:  result = reversed;
            ALU_LBI:  result = b;                    // Extended byte passes through
            ALU_SLBI: result = {a[7:0], b[7:0]};    // Old low byte moves up
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/instrDecoder.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic [executePkg::instrWidth-1:0]  instr,
    output executePkg::aluCtrl_t               ctrl,
    output logic [executePkg::regIdxWidth-1:0] rsIdx,
    output logic [executePkg::regIdxWidth-1:0] rtIdx,
    output logic [executePkg::regIdxWidth-1:0] rdIdx,
    output logic [executePkg::dataWidth-1:0]   immValue,
    output logic                               useImm,
    output logic                               writeEnable
);
    import executePkg::*;

    opcode_e              opcode;
    logic [dataWidth-1:0] imm5Sext;
    logic [dataWidth-1:0] imm5Zext;
    logic [dataWidth-1:0] imm8Sext;
    logic [dataWidth-1:0] imm8Zext;

    assign opcode = opcode_e'(instr[15:11]);

    assign imm5Sext = {{(dataWidth-5){instr[4]}}, instr[4:0]};
    assign imm5Zext = {{(dataWidth-5){1'b0}}, instr[4:0]};
    assign imm8Sext = {{(dataWidth-8){instr[7]}}, instr[7:0]};
    assign imm8Zext = {{(dataWidth-8){1'b0}}, instr[7:0]};

    always_comb begin
        // Register form unless overridden
        ctrl.op       = ALU_ADD;
        ctrl.invA     = 1'b0;
        ctrl.invB     = 1'b0;
        ctrl.carryIn  = 1'b0;
        ctrl.signedOp = 1'b0;
        rsIdx         = instr[10:8];
        rtIdx         = instr[7:5];
        rdIdx         = instr[4:2];
        immValue      = imm5Zext;
        useImm        = 1'b0;
        writeEnable   = 1'b1;

        case (opcode)
            OP_ADD, OP_ADDI: begin
                ctrl.signedOp = 1'b1;
            end
            OP_SUB, OP_SUBI: begin
                ctrl.invA     = 1'b1; // B minus A
                ctrl.carryIn  = 1'b1;
                ctrl.signedOp = 1'b1;
            end
            OP_XOR, OP_XORI:   ctrl.op = ALU_XOR;
            OP_ANDN, OP_ANDNI: begin
                ctrl.op   = ALU_AND;
                ctrl.invB = 1'b1;
            end
            OP_ROL, OP_ROLI: ctrl.op = ALU_ROL;
            OP_SLL, OP_SLLI: ctrl.op = ALU_SLL;
            OP_ROR, OP_RORI: ctrl.op = ALU_ROR;
            OP_SRL, OP_SRLI: ctrl.op = ALU_SRL;
            OP_SEQ, OP_SLT, OP_SLE: begin
                ctrl.invB     = 1'b1; // A minus B
                ctrl.carryIn  = 1'b1;
                ctrl.signedOp = 1'b1;
                ctrl.op = (opcode == OP_SEQ) ? ALU_SEQ :
                          (opcode == OP_SLT) ? ALU_SLT : ALU_SLE;
            end
            OP_SCO: ctrl.op = ALU_SCO;
            OP_BTR: ctrl.op = ALU_BTR;
            OP_LBI: begin
                ctrl.op  = ALU_LBI;
                rdIdx    = instr[10:8];
                immValue = imm8Sext;
                useImm   = 1'b1;
            end
            OP_SLBI: begin
                ctrl.op  = ALU_SLBI;
                rdIdx    = instr[10:8];
                immValue = imm8Zext;
                useImm   = 1'b1;
            end
            default: writeEnable = 1'b0; // Illegal opcode
        endcase

        // Immediate form moves rd and picks the imm5 extension
        case (opcode)
            OP_ADDI, OP_SUBI: begin
                rdIdx    = instr[7:5];
                immValue = imm5Sext;
                useImm   = 1'b1;
            end
            OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                rdIdx    = instr[7:5];
                immValue = imm5Zext;
                useImm   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
// Eight-entry register file
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [executePkg::regIdxWidth-1:0] readIdxA,
    input  logic [executePkg::regIdxWidth-1:0] readIdxB,
    output logic [executePkg::dataWidth-1:0]   readDataA,
    output logic [executePkg::dataWidth-1:0]   readDataB,
    input  logic                               writeEnable,
    input  logic [executePkg::regIdxWidth-1:0] writeIdx,
    input  logic [executePkg::dataWidth-1:0]   writeData
);
    import executePkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIdx] <= writeData; // r0 is writable too
        end
    end

    // Reads are combinational and see last edge's write
    assign readDataA = regs[readIdxA];
    assign readDataB = regs[readIdxB];

endmodule

`default_nettype wire

// File: logic/executeCore.sv
// Execute core top
`timescale 1ns/1ps
`default_nettype none

module executeCore (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               instrValid,
    input  logic [executePkg::instrWidth-1:0]  instr,
    output logic                               resultValid,
    output logic [executePkg::dataWidth-1:0]   result,
    output executePkg::aluFlags_t              flags,
    output logic [executePkg::regIdxWidth-1:0] resultReg,
    output logic                               illegal
);
    import executePkg::*;

    aluCtrl_t               ctrl;
    logic [regIdxWidth-1:0] rsIdx;
    logic [regIdxWidth-1:0] rtIdx;
    logic [regIdxWidth-1:0] rdIdx;
    logic [dataWidth-1:0]   immValue;
    logic                   useImm;
    logic                   decWriteEnable; // Legal opcode
    logic                   regWrite;
    logic [dataWidth-1:0]   rsData;
    logic [dataWidth-1:0]   rtData;
    logic [dataWidth-1:0]   operandB;
    logic [dataWidth-1:0]   aluResult;
    aluFlags_t              aluFlags;

    instrDecoder decoder0 (
        .instr      (instr),
        .ctrl       (ctrl),
        .rsIdx      (rsIdx),
        .rtIdx      (rtIdx),
        .rdIdx      (rdIdx),
        .immValue   (immValue),
        .useImm     (useImm),
        .writeEnable(decWriteEnable)
    );

    assign regWrite = instrValid & decWriteEnable;

    registerFile regFile0 (
        .clk        (clk),
        .reset      (reset),
        .readIdxA   (rsIdx),
        .readIdxB   (rtIdx),
        .readDataA  (rsData),
        .readDataB  (rtData),
        .writeEnable(regWrite),
        .writeIdx   (rdIdx),
        .writeData  (aluResult)
    );

    assign operandB = useImm ? immValue : rtData;

    alu alu0 (
        .operandA(rsData),
        .operandB(operandB),
        .ctrl    (ctrl),
        .result  (aluResult),
        .flags   (aluFlags)
    );

    // Outputs follow the write-back edge
    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            illegal     <= 1'b0;
            result      <= '0;
            flags       <= '0;
            resultReg   <= '0;
        end else begin
            resultValid <= instrValid;
            illegal     <= instrValid & ~decWriteEnable; // Only illegal codes skip writes
            if (instrValid) begin
                result    <= aluResult;
                flags     <= aluFlags;
                resultReg <= rdIdx;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/executeCoreTb.sv
// Execute core directed testbench
`timescale 1ns/1ps
`default_nettype none

module executeCoreTb;
    import executePkg::*;

    localparam int cycleLimit = 2000; // Roughly four times the instructions issued

    logic                   clk;
    logic                   reset;
    logic                   instrValid;
    logic [instrWidth-1:0]  instr;
    logic                   resultValid;
    logic [dataWidth-1:0]   result;
    aluFlags_t              flags;
    logic [regIdxWidth-1:0] resultReg;
    logic                   illegal;

    logic [dataWidth-1:0] modelRegs [regCount]; // Mirror of the register file
    int                   seed       = 32'h976a_be92;
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   testErrors = 0;       // Error count when the test began
    int                   cycleCount = 0;
    string                testName;

    executeCore dut0 (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .resultValid(resultValid),
        .result     (result),
        .flags      (flags),
        .resultReg  (resultReg),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the run did not complete", cycleCount);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic checkResult(input logic [dataWidth-1:0] expected,
                               input logic [dataWidth-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s result expected %h actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkFlags(input aluFlags_t expected, input aluFlags_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s flags expected %b actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkIndex(input logic [regIdxWidth-1:0] expected,
                              input logic [regIdxWidth-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s resultReg expected %0d actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkIllegal(input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s illegal expected %b actual %b", testName, expected, actual);
        end
    endtask

    // Expected result straight from the instruction rules
    function automatic logic [dataWidth-1:0] modelResult(input opcode_e op,
                                                         input logic [dataWidth-1:0] a,
                                                         input logic [dataWidth-1:0] b);
        logic [31:0]          doubled;
        logic [16:0]          wide;
        logic [dataWidth-1:0] rev;
        logic [dataWidth-1:0] rest;

        doubled = {a, a};
        wide    = {1'b0, a} + {1'b0, b};
        rev     = '0;
        rest    = a;
        repeat (dataWidth) begin
            rev  = {rev[dataWidth-2:0], rest[0]}; // Bit 0 ends up on top
            rest = rest >> 1;
        end
        case (op)
            OP_ADD, OP_ADDI:   return a + b;
            OP_SUB, OP_SUBI:   return b - a;
            OP_XOR, OP_XORI:   return a ^ b;
            OP_ANDN, OP_ANDNI: return a & ~b;
            OP_ROL, OP_ROLI: begin
                doubled = doubled << b[3:0];
                return doubled[31:16];
            end
            OP_SLL, OP_SLLI:   return a << b[3:0];
            OP_ROR, OP_RORI: begin
                doubled = doubled >> b[3:0];
                return doubled[15:0];
            end
            OP_SRL, OP_SRLI:   return a >> b[3:0];
            OP_SEQ:            return {15'b0, a == b};
            OP_SLT:            return {15'b0, $signed(a) < $signed(b)};
            OP_SLE:            return {15'b0, $signed(a) <= $signed(b)};
            OP_SCO:            return {15'b0, wide[16]};
            OP_BTR:            return rev;
            OP_LBI:            return b;
            default:           return (a << 8) | b; // SLBI
        endcase
    endfunction

    // Adder flags for whatever operands the opcode feeds the adder
    function automatic aluFlags_t modelFlags(input opcode_e op,
                                             input logic [dataWidth-1:0] a,
                                             input logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] x;
        logic [dataWidth-1:0] y;
        logic                 cin;
        logic                 signedRule;
        logic [16:0]          wide;
        int                   total;
        aluFlags_t            f;

        x          = a;
        y          = b;
        cin        = 1'b0;
        signedRule = 1'b0;
        case (op)
            OP_ADD, OP_ADDI:   signedRule = 1'b1;
            OP_SUB, OP_SUBI: begin
                x          = ~a; // B minus A
                cin        = 1'b1;
                signedRule = 1'b1;
            end
            OP_ANDN, OP_ANDNI: y = ~b;
            OP_SEQ, OP_SLT, OP_SLE: begin
                y          = ~b; // A minus B
                cin        = 1'b1;
                signedRule = 1'b1;
            end
            default: ;
        endcase
        wide       = {1'b0, x} + {1'b0, y} + {16'b0, cin};
        total      = int'($signed(x)) + int'($signed(y)) + int'(cin);
        f.zero     = (wide[15:0] == '0);
        f.sign     = wide[15];
        f.carry    = wide[16];
        f.overflow = signedRule ? (total > 32767 || total < -32768) : wide[16];
        return f;
    endfunction

    // Drives one word and returns 1 ns after the edge that retires it
    task automatic issueInstr(input logic [instrWidth-1:0] word);
        instr      = word;
        instrValid = 1'b1;
        @(posedge clk);
        #1;
        instrValid = 1'b0; // Next call raises it again before the edge
        checkCount++;
        if (resultValid !== 1'b1) begin
            errorCount++;
            $display("resultValid did not pulse for an instruction in test %s", testName);
        end
    endtask

    task automatic execOp(input opcode_e op, input logic [2:0] rs, input logic [2:0] rt,
                          input logic [2:0] rd, input logic [7:0] imm);
        logic [instrWidth-1:0] word;
        logic [dataWidth-1:0]  a;
        logic [dataWidth-1:0]  b;
        logic [2:0]            dest;
        logic [dataWidth-1:0]  expected;

        a = modelRegs[rs];
        case (op)
            OP_ADDI, OP_SUBI: begin
                word = {op, rs, rd, imm[4:0]};
                b    = {{11{imm[4]}}, imm[4:0]};
                dest = rd;
            end
            OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                word = {op, rs, rd, imm[4:0]};
                b    = {11'b0, imm[4:0]};
                dest = rd;
            end
            OP_LBI, OP_SLBI: begin
                word = {op, rs, imm}; // rs is also the destination
                b    = (op == OP_LBI) ? {{8{imm[7]}}, imm} : {8'b0, imm};
                dest = rs;
            end
            default: begin
                word = {op, rs, rt, rd, 2'b00};
                b    = modelRegs[rt];
                dest = rd;
            end
        endcase
        expected = modelResult(op, a, b);
        issueInstr(word);
        checkResult(expected, result);
        checkFlags(modelFlags(op, a, b), flags);
        checkIndex(dest, resultReg);
        checkIllegal(1'b0, illegal);
        modelRegs[dest] = expected;
    endtask

    task automatic loadValue(input logic [2:0] idx, input logic [dataWidth-1:0] value);
        execOp(OP_LBI, idx, 3'd0, 3'd0, value[15:8]);
        execOp(OP_SLBI, idx, 3'd0, 3'd0, value[7:0]);
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        $display("test %s finished with %0d errors", testName, errorCount - testErrors);
    endtask

    task automatic resetState();
        startTest("resetState");
        checkResult('0, result);
        checkFlags('0, flags);
        repeat (3) begin
            @(posedge clk);
            #1;
            checkIllegal(1'b0, illegal);
            checkCount++;
            if (resultValid !== 1'b0) begin
                errorCount++;
                $display("resultValid pulsed without an instruction in test %s", testName);
            end
        end
        execOp(OP_ADDI, 3'd3, 3'd0, 3'd4, 8'h00); // r3 reads back as zero
        endTest();
    endtask

    task automatic loadBytes();
        startTest("loadBytes");
        execOp(OP_LBI, 3'd1, 3'd0, 3'd0, 8'h80);
        execOp(OP_SLBI, 3'd1, 3'd0, 3'd0, 8'h5A);
        for (int i = 1; i < regCount; i++) begin
            loadValue(3'(i), 16'($random(seed)));
        end
        endTest();
    endtask

    task automatic addSubtract();
        logic [dataWidth-1:0] firstVals [3]  = '{16'h7FFF, 16'h8000, 16'h8000};
        logic [dataWidth-1:0] secondVals [3] = '{16'h0001, 16'h8000, 16'h0001};

        startTest("addSubtract");
        for (int i = 0; i < 8; i++) begin
            loadValue(3'd1, 16'($random(seed)));
            loadValue(3'd2, 16'($random(seed)));
            execOp(OP_ADD, 3'd1, 3'd2, 3'd3, 8'h00);
            execOp(OP_SUB, 3'd1, 3'd2, 3'd4, 8'h00);
            execOp(OP_ADDI, 3'd1, 3'd0, 3'd5, 8'($random(seed)));
            execOp(OP_SUBI, 3'd2, 3'd0, 3'd6, 8'($random(seed)));
        end
        // Signed overflow corners
        for (int i = 0; i < 3; i++) begin
            loadValue(3'd1, firstVals[i]);
            loadValue(3'd2, secondVals[i]);
            execOp(OP_ADD, 3'd1, 3'd2, 3'd3, 8'h00);
            execOp(OP_SUB, 3'd2, 3'd1, 3'd4, 8'h00);
            execOp(OP_ADDI, 3'd1, 3'd0, 3'd5, 8'h01);
            execOp(OP_SUBI, 3'd1, 3'd0, 3'd6, 8'h10);
        end
        endTest();
    endtask

    task automatic logicShifts();
        opcode_e regShifts [4] = '{OP_ROL, OP_SLL, OP_ROR, OP_SRL};
        opcode_e immShifts [4] = '{OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};

        startTest("logicShifts");
        for (int i = 0; i < 4; i++) begin
            loadValue(3'd1, 16'($random(seed)));
            loadValue(3'd2, 16'($random(seed)));
            execOp(OP_XOR, 3'd1, 3'd2, 3'd3, 8'h00);
            execOp(OP_ANDN, 3'd1, 3'd2, 3'd4, 8'h00);
            execOp(OP_XORI, 3'd1, 3'd0, 3'd5, 8'($random(seed)));
            execOp(OP_ANDNI, 3'd1, 3'd0, 3'd6, 8'($random(seed)));
        end
        loadValue(3'd1, 16'($random(seed)));
        for (int amt = 0; amt < 16; amt++) begin
            execOp(OP_LBI, 3'd2, 3'd0, 3'd0, {4'hF, 4'(amt)}); // Upper bits must be ignored
            for (int k = 0; k < 4; k++) begin
                execOp(regShifts[k], 3'd1, 3'd2, 3'd3, 8'h00);
                execOp(immShifts[k], 3'd1, 3'd0, 3'd4, {3'b000, 1'(amt), 4'(amt)});
            end
        end
        endTest();
    endtask

    task automatic conditions();
        logic [dataWidth-1:0] firstVal;
        logic [dataWidth-1:0] secondVal;
        opcode_e              condOps [4] = '{OP_SEQ, OP_SLT, OP_SLE, OP_SCO};

        startTest("conditions");
        for (int p = 0; p < 8; p++) begin
            firstVal  = 16'($random(seed));
            secondVal = 16'($random(seed));
            if (p == 0) begin
                secondVal = firstVal;
            end else if (p == 1) begin
                firstVal  = 16'h8000; // Most negative against most positive
                secondVal = 16'h7FFF;
            end
            loadValue(3'd1, firstVal);
            loadValue(3'd2, secondVal);
            for (int k = 0; k < 4; k++) begin
                execOp(condOps[k], 3'd1, 3'd2, 3'd3, 8'h00);
                execOp(condOps[k], 3'd2, 3'd1, 3'd4, 8'h00);
            end
        end
        for (int i = 0; i < 8; i++) begin
            loadValue(3'd1, 16'($random(seed)));
            execOp(OP_BTR, 3'd1, 3'd2, 3'd5, 8'h00);
        end
        endTest();
    endtask

    task automatic streamIllegal();
        startTest("streamIllegal");
        loadValue(3'd1, 16'h0010);
        // Each one reads the write from the edge before
        for (int i = 0; i < 6; i++) begin
            execOp(OP_ADDI, 3'd1, 3'd0, 3'd1, 8'h03);
        end
        execOp(OP_ADD, 3'd1, 3'd1, 3'd2, 8'h00);
        execOp(OP_SUB, 3'd2, 3'd1, 3'd2, 8'h00);
        loadValue(3'd5, 16'hBEEF);
        // Every field layout of these words points at r1 or r5
        issueInstr({5'b01100, 3'd1, 3'd5, 3'd5, 2'b00});
        checkIllegal(1'b1, illegal);
        issueInstr({5'b11010, 3'd5, 3'd5, 3'd5, 2'b00});
        checkIllegal(1'b1, illegal);
        execOp(OP_ADDI, 3'd5, 3'd0, 3'd6, 8'h00);
        execOp(OP_ADDI, 3'd1, 3'd0, 3'd7, 8'h00);
        endTest();
    endtask

    initial begin
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        modelRegs  = '{default: '0};
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        resetState();
        loadBytes();
        addSubtract();
        logicShifts();
        conditions();
        streamIllegal();
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
logic/executePkg.sv
logic/shifter.sv
logic/alu.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/executeCore.sv
test/executeCoreTb.sv

// File: runSim.sh
#!/bin/sh
# Builds and runs the execute core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module executeCoreTb

output=$(./obj_dir/VexecuteCoreTb)
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
